// File: run_sim.sh
#!/bin/sh
# build and run the line stream testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f \
    --top-module tb_ov5640_line_stream \
    -Mdir obj_dir -o sim_bin
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build returned status $status"
    exit 1
fi

output=$(./obj_dir/sim_bin)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
    exit 1
fi

# the verdict comes from the testbench output
if printf '%s\n' "$output" | grep -qx "sim passed"; then
    exit 0
fi
exit 1

// File: src/byte_serializer.sv
`timescale 1ns/1ps

module byte_serializer (
    input  logic                     ov5640_pclk,
    input  logic                     rst_n,
    input  logic                     empty,
    input  camera_pkg::stream_word_u rd_data,
    input  logic                     rd_tag,
    output logic                     rd,
    output logic                     tx_valid,
    output stream_pkg::stream_byte_t tx_byte,
    output logic                     tx_tag
);

    import stream_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_high,   // fetched word valid, send upper byte
        st_low     // send lower byte
    } ser_state_t;

    ser_state_t   state;
    logic [15:0]  word_bits;
    stream_byte_t high_byte;
    stream_byte_t low_byte;

    assign word_bits = rd_data;
    assign high_byte = word_bits[15:8];
    assign low_byte  = word_bits[7:0];

    // fetch while idle, or while the last byte of a word goes out
    // so words can follow back to back
    assign rd = ~empty & ((state == st_idle) | (state == st_low));

    always_ff @(posedge ov5640_pclk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: state <= rd ? st_high : st_idle;
                st_high: state <= st_low;
                st_low:  state <= rd ? st_high : st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    assign tx_valid = (state != st_idle);
    assign tx_byte  = (state == st_high) ? high_byte : low_byte;
    assign tx_tag   = tx_valid & rd_tag;   // same tag on both bytes

endmodule

// File: src/camera_pkg.sv
package camera_pkg;

    // pixels per line before the line word is inserted
    localparam logic [15:0] line_pixels = 16'd640;

    // one RGB565 pixel as the camera sends it, red in the top bits
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_t;

    // one 16-bit stream word
    // the tag bit that travels beside it picks the reading
    typedef union packed {
        rgb565_t     pixel;     // tag low
        logic [15:0] line_num;  // tag high, lines since vsync
    } stream_word_u;

endpackage

// File: src/line_tagger.sv
`timescale 1ns/1ps

module line_tagger (
    input  logic                     ov5640_pclk,
    input  logic                     rst_n,
    input  logic                     ov5640_href,
    input  logic                     ov5640_vsync,
    input  logic                     pix_valid,
    input  camera_pkg::rgb565_t      pix_data,
    output logic                     word_wr,
    output camera_pkg::stream_word_u word_data,
    output logic                     word_tag
);

    import camera_pkg::*;

    logic        href_d;
    logic        href_rise;
    logic [15:0] line_cnt;     // href rises since last vsync
    logic [15:0] pix_cnt;      // pixels in current line
    logic        line_full;
    logic        line_full_d;
    logic        tag_hit;

    assign href_rise = ov5640_href & ~href_d;
    assign line_full = (pix_cnt == line_pixels);
    assign tag_hit   = line_full & ~line_full_d;   // first cycle only

    always_ff @(posedge ov5640_pclk or negedge rst_n) begin
        if (!rst_n) begin
            href_d      <= 1'b0;
            line_full_d <= 1'b0;
        end else begin
            href_d      <= ov5640_href;
            line_full_d <= line_full;
        end
    end

    // line counter
    always_ff @(posedge ov5640_pclk or negedge rst_n) begin
        if (!rst_n) begin
            line_cnt <= '0;
        end else if (ov5640_vsync) begin
            line_cnt <= '0;
        end else if (href_rise) begin
            line_cnt <= line_cnt + 16'd1;
        end
    end

    // pixel counter, restarted by each new line
    always_ff @(posedge ov5640_pclk or negedge rst_n) begin
        if (!rst_n) begin
            pix_cnt <= '0;
        end else if (href_rise) begin
            pix_cnt <= '0;
        end else if (pix_valid) begin
            pix_cnt <= pix_cnt + 16'd1;
        end
    end

    // write strobe and tag
    always_ff @(posedge ov5640_pclk or negedge rst_n) begin
        if (!rst_n) begin
            word_wr  <= 1'b0;
            word_tag <= 1'b0;
        end else begin
            word_wr  <= pix_valid | tag_hit;
            word_tag <= tag_hit;
        end
    end

    // the line word lands one cycle after the last pixel word, so the two never collide
    always_ff @(posedge ov5640_pclk) begin
        if (tag_hit) begin
            word_data.line_num <= line_cnt;
        end else if (pix_valid) begin
            word_data.pixel <= pix_data;
        end
    end

endmodule

// File: src/ov5640_capture.sv
`timescale 1ns/1ps

module ov5640_capture (
    input  logic               ov5640_pclk,
    input  logic               rst_n,
    input  logic               ov5640_href,
    input  logic [7:0]         ov5640_data,
    output logic               pix_valid,
    output camera_pkg::rgb565_t pix_data
);

    import camera_pkg::*;

    logic       byte_phase;   // 0 = expecting high byte
    logic [7:0] high_byte;

    // byte phase and pixel strobe
    always_ff @(posedge ov5640_pclk or negedge rst_n) begin
        if (!rst_n) begin
            byte_phase <= 1'b0;
            pix_valid  <= 1'b0;
        end else begin
            pix_valid <= 1'b0;
            if (!ov5640_href) begin
                byte_phase <= 1'b0;          // realign on every href gap
            end else if (!byte_phase) begin
                byte_phase <= 1'b1;
            end else begin
                byte_phase <= 1'b0;
                pix_valid  <= 1'b1;          // low byte just sampled
            end
        end
    end

    // holds the first byte of the pair
    always_ff @(posedge ov5640_pclk) begin
        if (ov5640_href && !byte_phase) begin
            high_byte <= ov5640_data;
        end
    end

    // pixel assembly, payload only
    always_ff @(posedge ov5640_pclk) begin
        if (ov5640_href && byte_phase) begin
            pix_data <= rgb565_t'({high_byte, ov5640_data});
        end
    end

endmodule

// File: src/ov5640_line_stream.sv
`timescale 1ns/1ps

module ov5640_line_stream (
    input  logic                     ov5640_pclk,
    input  logic                     rst_n,
    input  logic                     ov5640_href,
    input  logic                     ov5640_vsync,
    input  logic [7:0]               ov5640_data,
    output logic                     tx_valid,
    output stream_pkg::stream_byte_t tx_byte,
    output logic                     tx_tag,
    output logic                     overflow
);

    import camera_pkg::*;

    logic         pix_valid;
    rgb565_t      pix_data;
    logic         word_wr;
    stream_word_u word_data;
    logic         word_tag;
    logic         fifo_rd;
    stream_word_u fifo_rd_data;
    logic         fifo_rd_tag;
    logic         fifo_empty;

    // byte pairing
    ov5640_capture i_ov5640_capture (
        .ov5640_pclk (ov5640_pclk),
        .rst_n       (rst_n),
        .ov5640_href (ov5640_href),
        .ov5640_data (ov5640_data),
        .pix_valid   (pix_valid),
        .pix_data    (pix_data)
    );

    line_tagger i_line_tagger (
        .ov5640_pclk  (ov5640_pclk),
        .rst_n        (rst_n),
        .ov5640_href  (ov5640_href),
        .ov5640_vsync (ov5640_vsync),
        .pix_valid    (pix_valid),
        .pix_data     (pix_data),
        .word_wr      (word_wr),
        .word_data    (word_data),
        .word_tag     (word_tag)
    );

    word_fifo i_word_fifo (
        .ov5640_pclk (ov5640_pclk),
        .rst_n       (rst_n),
        .wr          (word_wr),
        .wr_data     (word_data),
        .wr_tag      (word_tag),
        .rd          (fifo_rd),
        .rd_data     (fifo_rd_data),
        .rd_tag      (fifo_rd_tag),
        .empty       (fifo_empty),
        .overflow    (overflow)
    );

    // two bytes per word toward the sender
    byte_serializer i_byte_serializer (
        .ov5640_pclk (ov5640_pclk),
        .rst_n       (rst_n),
        .empty       (fifo_empty),
        .rd_data     (fifo_rd_data),
        .rd_tag      (fifo_rd_tag),
        .rd          (fifo_rd),
        .tx_valid    (tx_valid),
        .tx_byte     (tx_byte),
        .tx_tag      (tx_tag)
    );

endmodule

// File: src/stream_pkg.sv
package stream_pkg;

    // word buffer between the tagger and the byte output
    localparam int fifo_depth  = 16;
    localparam int fifo_addr_w = 4;   // log2 of fifo_depth

    // one output byte toward the UDP sender
    typedef logic [7:0] stream_byte_t;

endpackage

// File: src/word_fifo.sv
`timescale 1ns/1ps

module word_fifo (
    input  logic                     ov5640_pclk,
    input  logic                     rst_n,
    input  logic                     wr,
    input  camera_pkg::stream_word_u wr_data,
    input  logic                     wr_tag,
    input  logic                     rd,
    output camera_pkg::stream_word_u rd_data,
    output logic                     rd_tag,
    output logic                     empty,
    output logic                     overflow
);

    import camera_pkg::*;
    import stream_pkg::*;

    stream_word_u           word_mem [fifo_depth];
    logic                   tag_mem  [fifo_depth];
    logic [fifo_addr_w-1:0] wr_ptr;
    logic [fifo_addr_w-1:0] rd_ptr;
    logic [fifo_addr_w:0]   count;
    logic                   full;
    logic                   do_wr;
    logic                   do_rd;

    assign full  = (count == (fifo_addr_w + 1)'(fifo_depth));
    assign empty = (count == '0);
    assign do_wr = wr & ~full;     // dropped when full
    assign do_rd = rd & ~empty;

    // pointers wrap naturally at fifo_depth
    always_ff @(posedge ov5640_pclk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (wr && full) begin
                overflow <= 1'b1;   // sticky until reset
            end
        end
    end

    always_ff @(posedge ov5640_pclk) begin
        if (do_wr) begin
            word_mem[wr_ptr] <= wr_data;
            tag_mem[wr_ptr]  <= wr_tag;
        end
    end

    // registered read port
    always_ff @(posedge ov5640_pclk) begin
        if (do_rd) begin
            rd_data <= word_mem[rd_ptr];
            rd_tag  <= tag_mem[rd_ptr];
        end
    end

endmodule

// File: verification/line_stream_assert.sv
`timescale 1ns/1ps

module line_stream_assert (
    input logic ov5640_pclk,
    input logic rst_n,
    input logic word_wr,
    input logic word_tag,
    input logic tx_valid,
    input logic overflow
);

    int unsigned fail_count = 0;   // assertion failures so far

    // a tx_valid run never ends after one byte
    a_tx_pairs : assert property (@(posedge ov5640_pclk) disable iff (!rst_n)
        $rose(tx_valid) |=> tx_valid)
        else begin
            $error("tx_valid lasted a single cycle");
            fail_count++;
        end

    // two pixel words never on adjacent cycles
    a_pix_spacing : assert property (@(posedge ov5640_pclk) disable iff (!rst_n)
        (word_wr && !word_tag) |=> !(word_wr && !word_tag))
        else begin
            $error("pixel words written on adjacent cycles");
            fail_count++;
        end

    // line word goes in with word_wr, right after the last pixel word
    a_tag_with_wr : assert property (@(posedge ov5640_pclk) disable iff (!rst_n)
        word_tag |-> word_wr && $past(word_wr && !word_tag))
        else begin
            $error("word_tag without word_wr right after a pixel word");
            fail_count++;
        end

    // sticky until reset
    a_overflow_sticky : assert property (@(posedge ov5640_pclk) disable iff (!rst_n)
        overflow |=> overflow)
        else begin
            $error("overflow fell without reset");
            fail_count++;
        end

endmodule

bind ov5640_line_stream line_stream_assert i_line_stream_assert (
    .ov5640_pclk (ov5640_pclk),
    .rst_n       (rst_n),
    .word_wr     (word_wr),
    .word_tag    (word_tag),
    .tx_valid    (tx_valid),
    .overflow    (overflow)
);

// File: verification/line_stream_golden.txt
// columns: kind count start tag, kind 1 = vsync (count = width in cycles), kind 2 = line
// line: count = pixels, start = first pixel value, tag = expected line word, ffff = none
0001 0004 0000 0000
0002 0280 0000 0001
0002 0280 1234 0002
0002 0280 fe00 0003
0001 0003 0000 0000
0002 0280 0abc 0001
0002 0064 5555 ffff
0002 0280 7ffe 0003
0002 0280 c3a0 0004
0001 0002 0000 0000
0002 0025 0f0f ffff
0002 0280 8000 0002
0000 0000 0000 0000

// File: verification/tb_ov5640_line_stream.sv
`timescale 1ns/1ps

module tb_ov5640_line_stream;

    import camera_pkg::*;
    import stream_pkg::*;

    localparam int          drain_limit = 4000;      // cycles per wait
    localparam int          rec_words   = 4;
    localparam logic [15:0] no_tag      = 16'hffff;

    logic         ov5640_pclk;
    logic         rst_n;
    logic         ov5640_href;
    logic         ov5640_vsync;
    logic [7:0]   ov5640_data;
    logic         tx_valid;
    stream_byte_t tx_byte;
    logic         tx_tag;
    logic         overflow;

    logic [15:0]  golden_mem [0:63];
    stream_word_u got_q[$];
    logic         got_tag_q[$];
    stream_byte_t first_byte;
    logic         first_tag;
    logic         byte_phase;
    int           byte_errors;
    int           total_words;
    int           exp_total;
    int           errors;
    int           test_num;
    logic [15:0]  model_line;     // href rises since vsync
    bit           timed_out;

    ov5640_line_stream i_ov5640_line_stream (
        .ov5640_pclk  (ov5640_pclk),
        .rst_n        (rst_n),
        .ov5640_href  (ov5640_href),
        .ov5640_vsync (ov5640_vsync),
        .ov5640_data  (ov5640_data),
        .tx_valid     (tx_valid),
        .tx_byte      (tx_byte),
        .tx_tag       (tx_tag),
        .overflow     (overflow)
    );

    initial ov5640_pclk = 1'b0;
    always #50 ov5640_pclk = ~ov5640_pclk;

    // reassemble words with the high byte first
    always @(negedge ov5640_pclk) begin
        if (!rst_n) begin
            byte_phase = 1'b0;
        end else if (tx_valid) begin
            if (!byte_phase) begin
                first_byte = tx_byte;
                first_tag  = tx_tag;
                byte_phase = 1'b1;
            end else begin
                if (tx_tag !== first_tag) begin
                    byte_errors++;
                    $display("Fail @%0t: tag bit differs between the two bytes of word %0d",
                             $time, total_words);
                end
                got_q.push_back(stream_word_u'({first_byte, tx_byte}));
                got_tag_q.push_back(first_tag);
                total_words++;
                byte_phase = 1'b0;
            end
        end
    end

    task automatic check_word(input stream_word_u got, input logic got_tag,
                              input stream_word_u exp, input logic exp_tag, input int idx);
        bit bad;
        bad = (got_tag !== exp_tag);
        if (exp_tag) begin
            bad = bad | (got.line_num !== exp.line_num);
        end else begin
            bad = bad | (got.pixel.red !== exp.pixel.red) | (got.pixel.green !== exp.pixel.green)
                      | (got.pixel.blue !== exp.pixel.blue);
        end
        if (bad) begin
            errors++;
            if (exp_tag)
                $display("Fail @%0t: word %0d got %h tag %0b, expected line %0d tag 1",
                         $time, idx, got.line_num, got_tag, exp.line_num);
            else
                $display("Fail @%0t: word %0d got rgb %0d/%0d/%0d tag %0b, expected %0d/%0d/%0d",
                         $time, idx, got.pixel.red, got.pixel.green, got.pixel.blue, got_tag,
                         exp.pixel.red, exp.pixel.green, exp.pixel.blue);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("Fail @%0t: %s is %0b, expected %0b", $time, what, got, exp);
        end
    endtask

    task automatic wait_words(input int need, output bit ok);
        for (int n = 0; n < drain_limit && got_q.size() < need; n++) @(negedge ov5640_pclk);
        ok = (got_q.size() >= need);
        if (!ok) $display("timeout: only %0d of %0d words came out", got_q.size(), need);
    endtask

    task automatic wait_idle(output bit ok);
        int quiet;
        quiet = 0;
        for (int n = 0; n < drain_limit && quiet < 10; n++) begin
            @(negedge ov5640_pclk);
            quiet = tx_valid ? 0 : quiet + 1;
        end
        ok = (quiet >= 10);
        if (!ok) $display("timeout: output never went quiet");
    endtask

    task automatic drive_vsync(input int width);
        ov5640_vsync = 1'b1;
        repeat (width) @(negedge ov5640_pclk);
        ov5640_vsync = 1'b0;
        model_line   = '0;
    endtask

    task automatic run_line(input int npix, input logic [15:0] start, input logic [15:0] exp_line);
        stream_word_u exp_q[$];
        logic         exp_tag_q[$];
        stream_word_u w;
        logic [15:0]  pix;
        logic [15:0]  model_tag;
        int           err_before;
        bit           ok;
        test_num++;
        err_before = errors;
        model_line = model_line + 16'd1;
        model_tag  = (npix == int'(line_pixels)) ? model_line : no_tag;
        if (model_tag !== exp_line) begin
            errors++;
            $display("golden record of test %0d expects tag %h but the line count gives %h",
                     test_num, exp_line, model_tag);
        end
        for (int i = 0; i < npix; i++) begin
            w.pixel = rgb565_t'(start + 16'(i));
            exp_q.push_back(w);
            exp_tag_q.push_back(1'b0);
        end
        if (exp_line != no_tag) begin
            w.line_num = exp_line;
            exp_q.push_back(w);
            exp_tag_q.push_back(1'b1);
        end
        exp_total += exp_q.size();
        repeat (2 + int'($urandom % 8)) @(negedge ov5640_pclk);   // href low gap
        for (int i = 0; i < npix; i++) begin
            pix         = start + 16'(i);
            ov5640_href = 1'b1;
            ov5640_data = pix[15:8];
            @(negedge ov5640_pclk);
            ov5640_data = pix[7:0];
            @(negedge ov5640_pclk);
        end
        ov5640_href = 1'b0;
        ov5640_data = 8'h00;
        wait_words(exp_q.size(), ok);
        if (!ok) begin
            timed_out = 1'b1;
            return;
        end
        for (int i = 0; i < exp_q.size(); i++) begin
            check_word(got_q.pop_front(), got_tag_q.pop_front(), exp_q[i], exp_tag_q[i], i);
        end
        $display("test %0d: %0d pixels, tag %h, %0d words, %0d errors",
                 test_num, npix, exp_line, exp_q.size(), errors - err_before);
    endtask

    initial begin
        int unsigned seed_ret;
        int          rec;
        bit          ok;
        seed_ret     = $urandom(32'h2af9);
        rst_n        = 1'b0;
        ov5640_href  = 1'b0;
        ov5640_vsync = 1'b0;
        ov5640_data  = 8'h00;
        errors       = 0;
        byte_errors  = 0;
        total_words  = 0;
        exp_total    = 0;
        test_num     = 0;
        model_line   = '0;
        timed_out    = 1'b0;
        $readmemh("verification/line_stream_golden.txt", golden_mem);
        if ($isunknown(golden_mem[0])) begin
            errors++;
            $display("golden file could not be read");
        end
        repeat (5) @(negedge ov5640_pclk);
        rst_n = 1'b1;
        check_flag(overflow, 1'b0, "overflow after reset");
        rec = 0;
        while (!timed_out && rec < 16 && golden_mem[rec*rec_words] == 16'h0001
               || !timed_out && rec < 16 && golden_mem[rec*rec_words] == 16'h0002) begin
            if (golden_mem[rec*rec_words] == 16'h0001)
                drive_vsync(int'(golden_mem[rec*rec_words+1]));
            else
                run_line(int'(golden_mem[rec*rec_words+1]), golden_mem[rec*rec_words+2],
                         golden_mem[rec*rec_words+3]);
            rec++;
        end
        if (!timed_out) begin
            test_num++;
            wait_idle(ok);
            timed_out = !ok;
            if (got_q.size() != 0) begin
                errors++;
                $display("%0d unexpected extra words at the output", got_q.size());
            end
            if (total_words != exp_total) begin
                errors++;
                $display("Fail @%0t: %0d output words, expected %0d",
                         $time, total_words, exp_total);
            end
            check_flag(overflow, 1'b0, "overflow after all traffic");
            $display("test %0d: totals %0d words, overflow %0b", test_num, total_words, overflow);
        end
        errors += byte_errors;
        errors += int'(i_ov5640_line_stream.i_line_stream_assert.fail_count);
        $display("%0d tests, %0d words, %0d errors, timeout %0b",
                 test_num, total_words, errors, timed_out);
        if (errors == 0 && !timed_out)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// File: verilog.f
src/camera_pkg.sv
src/stream_pkg.sv
src/ov5640_capture.sv
src/line_tagger.sv
src/word_fifo.sv
src/byte_serializer.sv
src/ov5640_line_stream.sv
verification/line_stream_assert.sv
verification/tb_ov5640_line_stream.sv
